/* verilog.f */
game_pkg.sv
link_sync.sv
pick_decoder.sv
board_link.sv
verdict_unit.sv
game_fsm.sv
game_top.sv
game_checker.sv
tb_game_top.sv

/* run.sh */
#!/bin/sh
# Build and run the game testbench, the exit status reports pass or fail.
verilator --binary --assert -f verilog.f --top-module tb_game_top -o sim_game \
    && ./obj_dir/sim_game \
    || exit 1

/* tb_game_top.sv */
`timescale 1ns/1ns

module tb_game_top import game_pkg::*;;

    localparam int GRID_X0    = 112;  // Same layout as the DUT default.
    localparam int GRID_Y0    = 84;
    localparam int TILE_W     = 192;
    localparam int TILE_H     = 144;
    localparam int NUM_ROUNDS = 7;

    // One game round, see the table in the main block.
    typedef struct packed {
        logic       own_out;
        logic [1:0] own_col;
        logic [1:0] own_row;
        logic [1:0] guess_col;
        logic [1:0] guess_row;
        person_t    peer_person;
        logic       peer_first;
        result_t    peer_res;
        person_t    exp_person;
        result_t    exp_result;
    } round_t;

    logic        clk;
    logic        rst;
    coord_t      mouse_x;
    coord_t      mouse_y;
    logic        mouse_right;
    logic        start;
    person_t     peer_person;
    logic        peer_ready;
    result_t     peer_result;
    person_t     link_person;
    logic        link_ready;
    result_t     link_result;
    result_t     result;
    game_state_t state;
    round_t      rounds [NUM_ROUNDS];

    game_top #(
        .GRID_X0 (coord_t'(GRID_X0)),
        .GRID_Y0 (coord_t'(GRID_Y0)),
        .TILE_W  (coord_t'(TILE_W)),
        .TILE_H  (coord_t'(TILE_H))
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .mouse_x     (mouse_x),
        .mouse_y     (mouse_y),
        .mouse_right (mouse_right),
        .start       (start),
        .peer_person (peer_person),
        .peer_ready  (peer_ready),
        .peer_result (peer_result),
        .link_person (link_person),
        .link_ready  (link_ready),
        .link_result (link_result),
        .result      (result),
        .state       (state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_person(input string name, input person_t got, input person_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %s, expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_state(input string name, input game_state_t got,
                               input game_state_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %s, expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic wait_for_state(input game_state_t exp, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (state != exp && n < limit);
        if (state != exp) begin
            abort_run($sformatf("state never reached %s within %0d cycles", exp.name(), limit));
        end
    endtask

    task automatic wait_for_ready(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!link_ready && n < limit);
        if (!link_ready) begin
            abort_run("link_ready did not rise after the own pick");
        end
    endtask

    // Waits until the local or the outgoing result is decided.
    task automatic wait_for_decision(input logic outward, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((outward ? link_result : result) == RES_NONE && n < limit);
        if ((outward ? link_result : result) == RES_NONE) begin
            abort_run("no result was decided in time");
        end
    endtask

    function automatic coord_t tile_x(input int col);
        return coord_t'(GRID_X0 + col * TILE_W + int'($urandom % TILE_W));
    endfunction

    function automatic coord_t tile_y(input int row);
        return coord_t'(GRID_Y0 + row * TILE_H + int'($urandom % TILE_H));
    endfunction

    // Press the right button at one position and hold it for some cycles.
    task automatic click_at(input coord_t x, input coord_t y, input int hold);
        @(posedge clk);
        mouse_x     <= x;
        mouse_y     <= y;
        mouse_right <= 1'b1;
        repeat (hold) @(posedge clk);  // The first edge samples the press.
        mouse_right <= 1'b0;
    endtask

    // Peer board picks its person a little later than we do.
    task automatic reveal_peer(input person_t p);
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        peer_person <= p;
        @(posedge clk);
        peer_ready <= 1'b1;
    endtask

    task automatic play_round(input round_t r);
        @(posedge clk);
        peer_person <= PERSON_NONE;  // Peer starts its round too.
        peer_ready  <= 1'b0;
        peer_result <= RES_NONE;
        start       <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_state(ST_CHOOSE, 10);
        check_result("result", result, RES_NONE);
        check_person("link_person", link_person, PERSON_NONE);
        check_flag("link_ready", link_ready, 1'b0);
        check_result("link_result", link_result, RES_NONE);

        if (r.own_out) begin
            click_at(coord_t'($urandom % GRID_X0), tile_y(r.own_row), 1);  // Left margin.
            repeat (6) begin
                @(negedge clk);
                check_flag("link_ready", link_ready, 1'b0);
                check_state("state", state, ST_CHOOSE);
            end
        end
        click_at(tile_x(r.own_col), tile_y(r.own_row), 3);  // Held button, one pick only.
        wait_for_ready(10);
        check_person("link_person", link_person, r.exp_person);
        check_state("state", state, ST_WAIT_PEER);

        reveal_peer(r.peer_person);
        wait_for_state(ST_GUESS, 20);

        if (r.peer_first) begin
            @(posedge clk);
            peer_result <= r.peer_res;  // Peer judged before us.
            wait_for_decision(1'b0, 20);
            check_result("result", result, r.exp_result);
            wait_for_state(ST_DONE, 10);
            wait_for_decision(1'b1, 10);
            check_result("link_result", link_result, r.exp_result);
            click_at(tile_x(r.guess_col), tile_y(r.guess_row), 1);  // Too late to count.
            repeat (4) begin
                @(negedge clk);
                check_result("result", result, r.exp_result);
            end
            check_state("state", state, ST_DONE);
        end else begin
            click_at(tile_x(r.guess_col), tile_y(r.guess_row), 1);
            @(posedge clk);
            @(negedge clk);
            check_result("result", result, r.exp_result);  // Two edges after the click.
            @(posedge clk);
            @(negedge clk);
            check_result("link_result", link_result, r.exp_result);
            wait_for_state(ST_DONE, 10);
        end
    endtask

    initial begin
        rst         = 1'b1;
        mouse_x     = '0;
        mouse_y     = '0;
        mouse_right = 1'b0;
        start       = 1'b0;
        peer_person = PERSON_NONE;
        peer_ready  = 1'b0;
        peer_result = RES_NONE;
        void'($urandom(32'hda9d));

        // Columns: own outside first, own col, own row, guess col, guess row,
        // peer person, peer first, peer result, expected link_person, expected result.
        rounds[0] = '{1'b0, 2'd0, 2'd0, 2'd1, 2'd1, 4'd5, 1'b0, RES_NONE, 4'd1, RES_WIN};
        rounds[1] = '{1'b0, 2'd2, 2'd1, 2'd0, 2'd2, 4'd3, 1'b0, RES_NONE, 4'd6, RES_LOSE};
        rounds[2] = '{1'b1, 2'd1, 2'd2, 2'd2, 2'd2, 4'd9, 1'b0, RES_NONE, 4'd8, RES_WIN};
        rounds[3] = '{1'b0, 2'd2, 2'd0, 2'd0, 2'd0, 4'd4, 1'b1, RES_WIN, 4'd3, RES_LOSE};
        rounds[4] = '{1'b0, 2'd0, 2'd1, 2'd1, 2'd0, 4'd2, 1'b1, RES_LOSE, 4'd4, RES_WIN};
        rounds[5] = '{1'b0, 2'd1, 2'd0, 2'd2, 2'd2, 4'd9, 1'b0, RES_NONE, 4'd2, RES_WIN};
        rounds[6] = '{1'b1, 2'd2, 2'd2, 2'd0, 2'd1, 4'd1, 1'b0, RES_NONE, 4'd9, RES_LOSE};

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_result("result", result, RES_NONE);
        check_flag("link_ready", link_ready, 1'b0);
        check_person("link_person", link_person, PERSON_NONE);
        check_result("link_result", link_result, RES_NONE);
        check_state("state", state, ST_IDLE);

        click_at(tile_x(1), tile_y(1), 1);  // Pick before the first start is ignored.
        repeat (4) begin
            @(negedge clk);
            check_flag("link_ready", link_ready, 1'b0);
            check_state("state", state, ST_IDLE);
        end

        for (int i = 0; i < NUM_ROUNDS; i++) begin
            play_round(rounds[i]);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* game_checker.sv */
`timescale 1ns/1ns

module game_checker import game_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        pick_valid,
    input logic        link_ready,
    input result_t     result,
    input game_state_t state
);

    // One click gives a single strobe cycle.
    a_pick_single: assert property (@(posedge clk) disable iff (rst)
        pick_valid |=> !pick_valid)
        else $error("pick_valid stayed high for two cycles");

    // A decided game keeps its outcome until the next round starts.
    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        (result != RES_NONE) |=> (result == $past(result)) || (state == ST_CHOOSE))
        else $error("result changed before a new round");

    a_ready_idle: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) |=> !link_ready)
        else $error("link_ready rose while idle");

endmodule

bind game_top game_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .pick_valid (pick_valid),
    .link_ready (link_ready),
    .result     (result),
    .state      (state)
);

/* game_top.sv */
`timescale 1ns/1ns

module game_top import game_pkg::*; #(
    parameter coord_t GRID_X0 = 12'd112,  // 800x600 screen, centred grid.
    parameter coord_t GRID_Y0 = 12'd84,
    parameter coord_t TILE_W  = 12'd192,
    parameter coord_t TILE_H  = 12'd144
) (
    input  logic        clk,
    input  logic        rst,
    input  coord_t      mouse_x,
    input  coord_t      mouse_y,
    input  logic        mouse_right,
    input  logic        start,
    input  person_t     peer_person,  // Async, from the peer board.
    input  logic        peer_ready,
    input  result_t     peer_result,
    output person_t     link_person,  // To the peer board.
    output logic        link_ready,
    output result_t     link_result,
    output result_t     result,
    output game_state_t state
);

    logic    pick_valid;
    person_t pick_id;
    logic    latch_own;
    logic    judge;
    logic    clear;
    logic    guessing;
    person_t peer_person_s;
    logic    peer_ready_s;
    result_t peer_result_s;

    pick_decoder #(
        .GRID_X0 (GRID_X0),
        .GRID_Y0 (GRID_Y0),
        .TILE_W  (TILE_W),
        .TILE_H  (TILE_H)
    ) u_pick_decoder (
        .clk         (clk),
        .rst         (rst),
        .mouse_x     (mouse_x),
        .mouse_y     (mouse_y),
        .mouse_right (mouse_right),
        .pick_valid  (pick_valid),
        .pick_id     (pick_id)
    );

    game_fsm u_game_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .pick_valid (pick_valid),
        .peer_ready (peer_ready_s),
        .result     (result),
        .latch_own  (latch_own),
        .judge      (judge),
        .clear      (clear),
        .guessing   (guessing),
        .state      (state)
    );

    board_link u_board_link (
        .clk           (clk),
        .rst           (rst),
        .clear         (clear),
        .latch_own     (latch_own),
        .pick_id       (pick_id),
        .result        (result),
        .peer_person   (peer_person),
        .peer_ready    (peer_ready),
        .peer_result   (peer_result),
        .link_person   (link_person),
        .link_ready    (link_ready),
        .link_result   (link_result),
        .peer_person_s (peer_person_s),
        .peer_ready_s  (peer_ready_s),
        .peer_result_s (peer_result_s)
    );

    verdict_unit u_verdict_unit (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .judge       (judge),
        .guessing    (guessing),
        .guess       (pick_id),
        .peer_person (peer_person_s),
        .peer_result (peer_result_s),
        .result      (result)
    );

endmodule

/* game_fsm.sv */
`timescale 1ns/1ns

module game_fsm import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        pick_valid,
    input  logic        peer_ready,
    input  result_t     result,
    output logic        latch_own,
    output logic        judge,
    output logic        clear,
    output logic        guessing,
    output game_state_t state
);

    game_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_CHOOSE;
                end
            end
            ST_CHOOSE: begin
                if (pick_valid) begin
                    state_nxt = ST_WAIT_PEER;  // Secret person chosen.
                end
            end
            ST_WAIT_PEER: begin
                if (peer_ready) begin
                    state_nxt = ST_GUESS;
                end
            end
            ST_GUESS: begin
                if (result != RES_NONE) begin
                    state_nxt = ST_DONE;  // Local guess or peer result decided it.
                end
            end
            ST_DONE: begin
                if (start) begin
                    state_nxt = ST_CHOOSE;  // Next round.
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // Strobes decode straight from the state, same cycle as the event.
    assign clear     = start && (state == ST_IDLE || state == ST_DONE);
    assign latch_own = pick_valid && (state == ST_CHOOSE);
    assign judge     = pick_valid && (state == ST_GUESS);
    assign guessing  = (state == ST_GUESS);

endmodule

/* verdict_unit.sv */
`timescale 1ns/1ns

module verdict_unit import game_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    clear,
    input  logic    judge,
    input  logic    guessing,
    input  person_t guess,
    input  person_t peer_person,
    input  result_t peer_result,
    output result_t result
);

    result_t result_nxt;

    // The first decision of a round wins, later events are ignored.
    always_comb begin
        result_nxt = result;
        if (result == RES_NONE) begin
            if (judge) begin
                if (guess == peer_person) begin
                    result_nxt = RES_WIN;  // Guessed the peer's person.
                end else begin
                    result_nxt = RES_LOSE;
                end
            end else if (guessing) begin
                // Peer judged first, take the opposite outcome.
                case (peer_result)
                    RES_WIN:  result_nxt = RES_LOSE;
                    RES_LOSE: result_nxt = RES_WIN;
                    default:  result_nxt = RES_NONE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            result <= RES_NONE;
        end else begin
            result <= result_nxt;
        end
    end

endmodule

/* board_link.sv */
`timescale 1ns/1ns

module board_link import game_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    clear,
    input  logic    latch_own,
    input  person_t pick_id,
    input  result_t result,
    input  person_t peer_person,
    input  logic    peer_ready,
    input  result_t peer_result,
    output person_t link_person,
    output logic    link_ready,
    output result_t link_result,
    output person_t peer_person_s,
    output logic    peer_ready_s,
    output result_t peer_result_s
);

    // Outgoing secret person and ready flag.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            link_person <= PERSON_NONE;
            link_ready  <= 1'b0;
        end else if (latch_own) begin
            link_person <= pick_id;  // Held for the whole round.
            link_ready  <= 1'b1;
        end
    end

    // Local outcome goes out so the peer can mirror it.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            link_result <= RES_NONE;
        end else begin
            link_result <= result;
        end
    end

    // Incoming fields from the peer board.
    link_sync #(
        .payload_t (person_t)
    ) u_sync_person (
        .clk (clk),
        .rst (rst),
        .d   (peer_person),
        .q   (peer_person_s)
    );

    link_sync #(
        .payload_t (logic)
    ) u_sync_ready (
        .clk (clk),
        .rst (rst),
        .d   (peer_ready),
        .q   (peer_ready_s)
    );

    link_sync #(
        .payload_t (result_t)
    ) u_sync_result (
        .clk (clk),
        .rst (rst),
        .d   (peer_result),
        .q   (peer_result_s)
    );

endmodule

/* pick_decoder.sv */
`timescale 1ns/1ns

module pick_decoder import game_pkg::*; #(
    parameter coord_t GRID_X0 = 12'd112,
    parameter coord_t GRID_Y0 = 12'd84,
    parameter coord_t TILE_W  = 12'd192,
    parameter coord_t TILE_H  = 12'd144
) (
    input  logic    clk,
    input  logic    rst,
    input  coord_t  mouse_x,
    input  coord_t  mouse_y,
    input  logic    mouse_right,
    output logic    pick_valid,
    output person_t pick_id
);

    logic       btn_q;  // Button level from the previous edge.
    logic       press;
    logic [2:0] col_hit;  // {inside, index}.
    logic [2:0] row_hit;

    // Walks the tile boundaries of one axis and returns {inside, index}.
    function automatic logic [2:0] locate(input coord_t pos, input coord_t origin,
                                          input coord_t size, input int count);
        logic [2:0] found;
        int         offset;
        found  = 3'b000;
        offset = int'(pos) - int'(origin);
        if (pos >= origin) begin
            for (int i = 0; i < count; i++) begin
                if (!found[2] && offset < (i + 1) * int'(size)) begin
                    found = {1'b1, 2'(i)};
                end
            end
        end
        return found;
    endfunction

    assign press   = mouse_right && !btn_q;  // Rising edge of the button.
    assign col_hit = locate(mouse_x, GRID_X0, TILE_W, GRID_COLS);
    assign row_hit = locate(mouse_y, GRID_Y0, TILE_H, GRID_ROWS);

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_q      <= 1'b0;
            pick_valid <= 1'b0;
        end else begin
            btn_q      <= mouse_right;
            pick_valid <= press && col_hit[2] && row_hit[2];  // Clicks off the grid are dropped.
        end
    end

    // Person number row * 3 + column + 1.
    always_ff @(posedge clk) begin
        if (press) begin
            pick_id <= person_t'(int'(row_hit[1:0]) * GRID_COLS + int'(col_hit[1:0]) + 1);
        end
    end

endmodule

/* link_sync.sv */
`timescale 1ns/1ns

module link_sync #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,  // Asynchronous field from the peer board.
    output payload_t q   // Same field in the local clock domain.
);

    payload_t meta;  // First stage, may go metastable.
    payload_t stable;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta   <= payload_t'(0);
            stable <= payload_t'(0);
        end else begin
            meta   <= d;
            stable <= meta;  // Two edges from d to q.
        end
    end

    assign q = stable;

endmodule

/* game_pkg.sv */
package game_pkg;

    // Portrait number, 0 = no person, 1..9 = grid cells in row-major order.
    typedef logic [3:0] person_t;

    localparam person_t PERSON_NONE = 4'd0;  // Nobody chosen yet.

    // Outcome codes, shared with the peer board over the link.
    typedef enum logic [1:0] {
        RES_NONE = 2'b00,  // Game still running.
        RES_LOSE = 2'b01,  // Local player lost.
        RES_WIN  = 2'b10   // Local player won.
    } result_t;

    // Screen coordinate as delivered by the mouse decoder.
    typedef logic [11:0] coord_t;

    // Game phases, also shown on the display.
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,  // After reset, waiting for start.
        ST_CHOOSE    = 3'd1,  // Player picks the secret person.
        ST_WAIT_PEER = 3'd2,  // Waiting for the peer to pick.
        ST_GUESS     = 3'd3,  // One click to guess.
        ST_DONE      = 3'd4   // Result shown.
    } game_state_t;

    // Shape of the portrait grid, fixed by the 4-bit person code.
    localparam int GRID_COLS = 3;
    localparam int GRID_ROWS = 3;

endpackage
